// ==== source/soc_bus_pkg.sv ====
package soc_bus_pkg;

    typedef struct packed {
        logic [31:0] address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        logic [31:0] wrdata;
    } dbus_req_t;

    typedef struct packed {
        logic [31:0] rddata;
        logic        stall;
    } dbus_rsp_t;

    typedef struct packed {
        logic [15:0] address;       // Byte offset inside the slave window.
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        logic [31:0] wrdata;
    } slave_req_t;

    typedef struct packed {
        logic [31:0] rddata;
        logic        stall;
    } slave_rsp_t;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_GPIO,
        TGT_TICKER,
        TGT_NONE
    } dbus_target_e;

    localparam logic [31:0] RAM_BASE    = 32'h8000_0000;
    localparam logic [31:0] GPIO_BASE   = 32'hBFD0_0000;
    localparam logic [31:0] TICKER_BASE = 32'hBFD0_0100;

    localparam int RAM_WIN_BITS = 16;  // 64 KiB window.
    localparam int REG_WIN_BITS = 8;   // 256 byte register windows.

    localparam logic [7:0] GPIO_OUT_OFS   = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS    = 8'h04;
    localparam logic [7:0] TICK_COUNT_OFS = 8'h00;
    localparam logic [7:0] TICK_CMP_OFS   = 8'h04;
    localparam logic [7:0] TICK_STAT_OFS  = 8'h08;

    // Replaces the bytes of old_word that are selected by be.
    function automatic logic [31:0] be_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== source/dbus_decoder.sv ====
`timescale 1ns/100ps
module dbus_decoder
    import soc_bus_pkg::*;
(
    input  logic       clk_bus_i,
    input  logic       rst_n_i,
    input  dbus_req_t  master_req_i,
    output dbus_rsp_t  master_rsp_o,
    output slave_req_t ram_req_o,
    output slave_req_t gpio_req_o,
    output slave_req_t ticker_req_o,
    input  slave_rsp_t ram_rsp_i,
    input  slave_rsp_t gpio_rsp_i,
    input  slave_rsp_t ticker_rsp_i
);

    dbus_target_e addr_tgt;
    dbus_target_e sel_tgt;
    dbus_target_e tgt_q;
    logic         busy_q;
    logic         active;
    logic [15:0]  ram_ofs;
    logic [15:0]  reg_ofs;

    function automatic dbus_target_e decode(input logic [31:0] addr);
        if (addr[31:RAM_WIN_BITS] == RAM_BASE[31:RAM_WIN_BITS]) begin
            return TGT_RAM;
        end
        if (addr[31:REG_WIN_BITS] == GPIO_BASE[31:REG_WIN_BITS]) begin
            return TGT_GPIO;
        end
        if (addr[31:REG_WIN_BITS] == TICKER_BASE[31:REG_WIN_BITS]) begin
            return TGT_TICKER;
        end
        return TGT_NONE;
    endfunction

    // Forwards the master request with the strobes gated by sel.
    function automatic slave_req_t route(input dbus_req_t   req,
                                         input logic [15:0] ofs,
                                         input logic        sel);
        slave_req_t sreq;
        sreq.address    = ofs;
        sreq.byteenable = req.byteenable;
        sreq.read       = req.read & sel;
        sreq.write      = req.write & sel;
        sreq.wrdata     = req.wrdata;
        return sreq;
    endfunction

    assign active   = master_req_i.read | master_req_i.write;
    assign addr_tgt = decode(master_req_i.address);
    assign sel_tgt  = busy_q ? tgt_q : addr_tgt;  // Hold the slave that began the access.

    assign ram_ofs = master_req_i.address[RAM_WIN_BITS-1:0];
    assign reg_ofs = 16'(master_req_i.address[REG_WIN_BITS-1:0]);

    assign ram_req_o    = route(master_req_i, ram_ofs, sel_tgt == TGT_RAM);
    assign gpio_req_o   = route(master_req_i, reg_ofs, sel_tgt == TGT_GPIO);
    assign ticker_req_o = route(master_req_i, reg_ofs, sel_tgt == TGT_TICKER);

    always_comb begin
        case (sel_tgt)
            TGT_RAM: begin
                master_rsp_o.rddata = ram_rsp_i.rddata;
                master_rsp_o.stall  = ram_rsp_i.stall;
            end
            TGT_GPIO: begin
                master_rsp_o.rddata = gpio_rsp_i.rddata;
                master_rsp_o.stall  = gpio_rsp_i.stall;
            end
            TGT_TICKER: begin
                master_rsp_o.rddata = ticker_rsp_i.rddata;
                master_rsp_o.stall  = ticker_rsp_i.stall;
            end
            default: begin
                master_rsp_o.rddata = '0;      // Unmapped reads return zero.
                master_rsp_o.stall  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            tgt_q  <= TGT_NONE;
        end else begin
            busy_q <= active & master_rsp_o.stall;
            if (active & master_rsp_o.stall) begin
                tgt_q <= sel_tgt;
            end
        end
    end

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/100ps
module data_ram
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10,
    parameter int RAM_WAIT       = 1
) (
    input  logic       clk_bus_i,
    input  logic       rst_n_i,
    input  slave_req_t req_i,
    output slave_rsp_t rsp_o
);

    localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;
    localparam int CNT_W = $clog2(RAM_WAIT + 2);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(RAM_WAIT + 1);

    logic [31:0]               mem [0:DEPTH-1];
    logic [31:0]               rd_q;
    logic [CNT_W-1:0]          wait_cnt_q;
    logic [RAM_ADDR_WIDTH-1:0] word_idx;
    logic                      active;
    logic                      done;

    assign word_idx = req_i.address[RAM_ADDR_WIDTH+1:2];
    assign active   = req_i.read | req_i.write;
    assign done     = active && (wait_cnt_q == LAST_CNT);

    assign rsp_o.stall  = active & ~done;
    assign rsp_o.rddata = rd_q;

    // Counts the stall cycles and drops back to idle after the completing cycle,
    // so a strobe that stays high starts the next access from zero.
    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_cnt_q <= '0;
        end else if (!active || done) begin
            wait_cnt_q <= '0;
        end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (req_i.read) begin
            rd_q <= mem[word_idx];                 // Settles while the access stalls.
        end
        if (req_i.write && done) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wrdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/100ps
module gpio_regs
    import soc_bus_pkg::*;
(
    input  logic        clk_bus_i,
    input  logic        rst_n_i,
    input  slave_req_t  req_i,
    output slave_rsp_t  rsp_o,
    input  logic [31:0] gpio_i,
    output logic [31:0] gpio_o
);

    logic [31:0] gpio_out_q;
    logic [31:0] gpio_meta_q;
    logic [31:0] gpio_sync_q;
    logic [31:0] rd_q;
    logic [31:0] rd_mux;
    logic        rd_done_q;

    assign gpio_o = gpio_out_q;

    assign rsp_o.stall  = req_i.read & ~rd_done_q;
    assign rsp_o.rddata = rd_q;

    always_comb begin
        case (req_i.address[7:0])
            GPIO_OUT_OFS: rd_mux = gpio_out_q;
            GPIO_IN_OFS:  rd_mux = gpio_sync_q;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_out_q  <= '0;
            gpio_meta_q <= '0;
            gpio_sync_q <= '0;
            rd_done_q   <= 1'b0;
        end else begin
            gpio_meta_q <= gpio_i;
            gpio_sync_q <= gpio_meta_q;
            rd_done_q   <= req_i.read & ~rd_done_q;
            if (req_i.write && req_i.address[7:0] == GPIO_OUT_OFS) begin
                gpio_out_q <= be_merge(gpio_out_q, req_i.wrdata, req_i.byteenable);
            end
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (req_i.read && !rd_done_q) begin
            rd_q <= rd_mux;
        end
    end

endmodule

// ==== source/ticker.sv ====
`timescale 1ns/100ps
module ticker
    import soc_bus_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  logic       clk_bus_i,
    input  logic       rst_n_i,
    input  slave_req_t req_i,
    output slave_rsp_t rsp_o,
    output logic       irq_o
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_q;
    logic [31:0]      count_q;
    logic [31:0]      cmp_q;
    logic [31:0]      rd_q;
    logic [31:0]      rd_mux;
    logic             stat_q;
    logic             hit_q;
    logic             rd_done_q;
    logic             tick;
    logic             hit;
    logic             wr_count;
    logic             wr_cmp;
    logic             clr_stat;

    assign tick     = (div_q == DIV_W'(TICK_DIV - 1));
    assign hit      = (count_q == cmp_q) && (cmp_q != '0);
    assign wr_count = req_i.write && req_i.address[7:0] == TICK_COUNT_OFS;
    assign wr_cmp   = req_i.write && req_i.address[7:0] == TICK_CMP_OFS;
    assign clr_stat = req_i.write && req_i.address[7:0] == TICK_STAT_OFS
                      && req_i.byteenable[0] && req_i.wrdata[0];

    assign irq_o        = stat_q;
    assign rsp_o.stall  = req_i.read & ~rd_done_q;
    assign rsp_o.rddata = rd_q;

    always_comb begin
        case (req_i.address[7:0])
            TICK_COUNT_OFS: rd_mux = count_q;
            TICK_CMP_OFS:   rd_mux = cmp_q;
            TICK_STAT_OFS:  rd_mux = {31'b0, stat_q};
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q     <= '0;
            count_q   <= '0;
            cmp_q     <= '0;
            stat_q    <= 1'b0;
            hit_q     <= 1'b0;
            rd_done_q <= 1'b0;
        end else begin
            div_q     <= tick ? '0 : div_q + 1'b1;
            hit_q     <= hit;
            rd_done_q <= req_i.read & ~rd_done_q;
            if (wr_count) begin
                count_q <= be_merge(count_q, req_i.wrdata, req_i.byteenable);
            end else if (tick) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_cmp) begin
                cmp_q <= be_merge(cmp_q, req_i.wrdata, req_i.byteenable);
            end
            // Only a fresh match sets the flag, so a clear holds while the count still matches.
            if (hit && !hit_q) begin
                stat_q <= 1'b1;
            end else if (clr_stat) begin
                stat_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (req_i.read && !rd_done_q) begin
            rd_q <= rd_mux;
        end
    end

endmodule

// ==== source/soc_dbus_top.sv ====
`timescale 1ns/100ps
module soc_dbus_top
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10,
    parameter int RAM_WAIT       = 1,
    parameter int TICK_DIV       = 4
) (
    input  logic        clk_bus_i,
    input  logic        rst_n_i,
    input  dbus_req_t   dbus_req_i,
    output dbus_rsp_t   dbus_rsp_o,
    input  logic [31:0] gpio_i,
    output logic [31:0] gpio_o,
    output logic        irq_o
);

    slave_req_t ram_req;
    slave_req_t gpio_req;
    slave_req_t ticker_req;
    slave_rsp_t ram_rsp;
    slave_rsp_t gpio_rsp;
    slave_rsp_t ticker_rsp;

    dbus_decoder u_dbus_decoder (
        .clk_bus_i    (clk_bus_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (dbus_req_i),
        .master_rsp_o (dbus_rsp_o),
        .ram_req_o    (ram_req),
        .gpio_req_o   (gpio_req),
        .ticker_req_o (ticker_req),
        .ram_rsp_i    (ram_rsp),
        .gpio_rsp_i   (gpio_rsp),
        .ticker_rsp_i (ticker_rsp)
    );

    data_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .RAM_WAIT       (RAM_WAIT)
    ) u_data_ram (
        .clk_bus_i (clk_bus_i),
        .rst_n_i   (rst_n_i),
        .req_i     (ram_req),
        .rsp_o     (ram_rsp)
    );

    gpio_regs u_gpio_regs (
        .clk_bus_i (clk_bus_i),
        .rst_n_i   (rst_n_i),
        .req_i     (gpio_req),
        .rsp_o     (gpio_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o)
    );

    ticker #(
        .TICK_DIV (TICK_DIV)
    ) u_ticker (
        .clk_bus_i (clk_bus_i),
        .rst_n_i   (rst_n_i),
        .req_i     (ticker_req),
        .rsp_o     (ticker_rsp),
        .irq_o     (irq_o)
    );

endmodule

// ==== verification/soc_dbus_sva.sv ====
`timescale 1ns/100ps
module soc_dbus_sva
    import soc_bus_pkg::*;
(
    input logic       clk_bus_i,
    input logic       rst_n_i,
    input dbus_req_t  master_req_i,
    input dbus_rsp_t  master_rsp_o,
    input slave_req_t ram_req_o,
    input slave_req_t gpio_req_o,
    input slave_req_t ticker_req_o
);

    logic master_active;
    logic ram_strobe;
    logic gpio_strobe;
    logic ticker_strobe;

    assign master_active = master_req_i.read | master_req_i.write;
    assign ram_strobe    = ram_req_o.read | ram_req_o.write;
    assign gpio_strobe   = gpio_req_o.read | gpio_req_o.write;
    assign ticker_strobe = ticker_req_o.read | ticker_req_o.write;

    req_stable: assert property (@(posedge clk_bus_i) disable iff (!rst_n_i)
        master_active && master_rsp_o.stall |=> $stable(master_req_i))
        else $error("Master request changed while stall was high.");

    no_read_write: assert property (@(posedge clk_bus_i) disable iff (!rst_n_i)
        !(master_req_i.read && master_req_i.write))
        else $error("Read and write were high together.");

    one_strobe: assert property (@(posedge clk_bus_i) disable iff (!rst_n_i)
        $onehot0({ram_strobe, gpio_strobe, ticker_strobe}))
        else $error("More than one slave strobe was high.");

    idle_no_stall: assert property (@(posedge clk_bus_i) disable iff (!rst_n_i)
        !master_active |-> !master_rsp_o.stall)
        else $error("Stall was high on an idle bus.");

    reset_no_stall: assert property (@(posedge clk_bus_i)
        $rose(rst_n_i) |-> !master_rsp_o.stall)
        else $error("Stall was high right after reset.");

endmodule

bind dbus_decoder soc_dbus_sva u_soc_dbus_sva (
    .clk_bus_i    (clk_bus_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req_i),
    .master_rsp_o (master_rsp_o),
    .ram_req_o    (ram_req_o),
    .gpio_req_o   (gpio_req_o),
    .ticker_req_o (ticker_req_o)
);

// ==== verification/tb_soc_dbus.sv ====
`timescale 1ns/100ps
module tb_soc_dbus
    import soc_bus_pkg::*;
();

    localparam int RAM_ADDR_WIDTH = 10;
    localparam int RAM_WAIT       = 1;
    localparam int TICK_DIV       = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int MAX_CASES      = 64;

    localparam logic [31:0] NO_CASE = 32'hFFFF_FFFF;

    logic        clk_bus = 1'b0;
    logic        rst_n;
    dbus_req_t   bus_req;
    dbus_rsp_t   bus_rsp;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic        irq;

    logic [31:0] case_words [0:5*MAX_CASES-1];
    logic [31:0] rand_model [logic [31:0]];   // Random words written so far, by address.
    int          n_cases = 0;
    integer      seed;

    soc_dbus_top #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .RAM_WAIT       (RAM_WAIT),
        .TICK_DIV       (TICK_DIV)
    ) u_soc_dbus_top (
        .clk_bus_i  (clk_bus),
        .rst_n_i    (rst_n),
        .dbus_req_i (bus_req),
        .dbus_rsp_o (bus_rsp),
        .gpio_i     (gpio_in),
        .gpio_o     (gpio_out),
        .irq_o      (irq)
    );

    always #(CLK_PERIOD / 2) clk_bus = ~clk_bus;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Test FAILED");
            $fatal(1, "Value mismatch.");
        end
    endtask

    // RAM accesses wait RAM_WAIT + 1 cycles, register reads one, register writes none.
    function automatic int expected_stalls(input logic [31:0] addr, input logic is_read);
        if (addr[31:16] == 16'h8000) return RAM_WAIT + 1;
        if (addr >= 32'hBFD0_0000 && addr < 32'hBFD0_0200) return is_read ? 1 : 0;
        return 0;
    endfunction

    // Starts 1 ns after a rising edge and returns 1 ns after the completing edge.
    task automatic bus_access(input logic is_read, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] data,
                              output logic [31:0] rd);
        int stalls;
        stalls             = 0;
        bus_req.address    = addr;
        bus_req.byteenable = be;
        bus_req.wrdata     = data;
        bus_req.read       = is_read;
        bus_req.write      = ~is_read;
        @(negedge clk_bus);
        while (bus_rsp.stall) begin
            stalls++;
            @(negedge clk_bus);
        end
        rd = bus_rsp.rddata;
        check(32'(stalls), 32'(expected_stalls(addr, is_read)),
              $sformatf("stall cycles at %h", addr));
        @(posedge clk_bus);
        #1;
        bus_req.read  = 1'b0;
        bus_req.write = 1'b0;
    endtask

    task automatic run_case(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] rd;
        logic [31:0] word;
        logic [3:0]  be;
        op      = case_words[5*idx];
        addr    = case_words[5*idx+1];
        be      = case_words[5*idx+2][3:0];
        data    = case_words[5*idx+3];
        exp_val = case_words[5*idx+4];
        case (op)
            32'd0: bus_access(1'b0, addr, be, data, rd);
            32'd1: begin
                bus_access(1'b1, addr, be, data, rd);
                check(rd, exp_val, $sformatf("case %0d read of %h", idx, addr));
            end
            32'd2: begin
                gpio_in = data;
                repeat (2) @(posedge clk_bus);   // Let the input synchroniser settle.
                #1;
            end
            32'd3: begin
                word = $random(seed);
                rand_model[addr] = word;
                bus_access(1'b0, addr, be, word, rd);
            end
            32'd4: begin
                bus_access(1'b1, addr, be, data, rd);
                check(rd, rand_model[addr], $sformatf("case %0d random word at %h", idx, addr));
            end
            32'd5: check(gpio_out, exp_val, $sformatf("case %0d gpio_o", idx));
            default: begin
                $display("Case %0d holds an unknown operation code %h.", idx, op);
                $display("Test FAILED");
                $fatal(1, "Bad cases file.");
            end
        endcase
    endtask

    task automatic timer_checks();
        logic [31:0] rd;
        int          waited;
        bus_access(1'b0, {TICKER_BASE[31:8], TICK_COUNT_OFS}, 4'hf, 32'd0, rd);
        bus_access(1'b0, {TICKER_BASE[31:8], TICK_CMP_OFS}, 4'hf, 32'd10, rd);
        waited = 0;
        while (!irq && waited < 10 * TICK_DIV + 4) begin
            @(negedge clk_bus);
            waited++;
        end
        check(32'(irq), 32'd1, "irq_o after compare match");
        @(posedge clk_bus);
        #1;
        bus_access(1'b1, {TICKER_BASE[31:8], TICK_COUNT_OFS}, 4'hf, 32'd0, rd);
        check(32'(rd >= 32'd10), 32'd1, "count at interrupt reaches compare");
        bus_access(1'b1, {TICKER_BASE[31:8], TICK_STAT_OFS}, 4'hf, 32'd0, rd);
        check(rd, 32'd1, "status bit while irq_o is high");
        bus_access(1'b0, {TICKER_BASE[31:8], TICK_STAT_OFS}, 4'h1, 32'd1, rd);
        @(negedge clk_bus);
        check(32'(irq), 32'd0, "irq_o after status clear");
        @(posedge clk_bus);
        #1;
        bus_access(1'b0, {TICKER_BASE[31:8], TICK_CMP_OFS}, 4'hf, 32'd0, rd);
        bus_access(1'b0, {TICKER_BASE[31:8], TICK_COUNT_OFS}, 4'hf, 32'd0, rd);
        repeat (20 * TICK_DIV) begin
            @(negedge clk_bus);
            check(32'(irq), 32'd0, "irq_o with compare zero");
        end
        @(posedge clk_bus);
        #1;
    endtask

    initial begin
        wait (n_cases > 0);
        #((n_cases * (RAM_WAIT + 2) + 200 + 100) * CLK_PERIOD);
        $display("The run timed out at %0t before all checks finished.", $time);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        seed    = 32'hbba17f44;
        rst_n   = 1'b0;
        bus_req = '0;
        gpio_in = '0;
        for (int i = 0; i < 5 * MAX_CASES; i++) case_words[i] = NO_CASE;  // Marks unused rows.
        $readmemh("verification/dbus_cases.txt", case_words);
        while (n_cases < MAX_CASES && case_words[5*n_cases] != NO_CASE) n_cases++;
        if (n_cases == 0) begin
            $display("No cases could be loaded from the cases file.");
            $display("Test FAILED");
            $fatal(1, "Empty cases file.");
        end
        repeat (4) @(posedge clk_bus);
        #1;
        rst_n = 1'b1;
        @(negedge clk_bus);
        check(32'(bus_rsp.stall), 32'd0, "stall after reset");
        check(gpio_out, 32'd0, "gpio_o after reset");
        check(32'(irq), 32'd0, "irq_o after reset");
        @(posedge clk_bus);
        #1;
        for (int i = 0; i < n_cases; i++) run_case(i);
        timer_checks();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verification/dbus_cases.txt ====
// Columns in hex: op address byteenable data expected.
// op 0 write, 1 read, 2 set gpio_i, 3 write random word, 4 read random word, 5 check gpio_o.
0 80000000 f 12345678 00000000
0 80000004 f cafef00d 00000000
0 800003fc f a5a55a5a 00000000
3 80000010 f 00000000 00000000
3 80000020 f 00000000 00000000
1 80000000 f 00000000 12345678
1 80000004 f 00000000 cafef00d
1 800003fc f 00000000 a5a55a5a
4 80000010 f 00000000 00000000
4 80000020 f 00000000 00000000
0 80000004 5 11223344 00000000
1 80000004 f 00000000 ca22f044
0 80000000 a ffffffff 00000000
1 80000000 f 00000000 ff34ff78
0 bfd00000 3 0000beef 00000000
0 bfd00000 c dead0000 00000000
5 00000000 0 00000000 deadbeef
1 bfd00000 f 00000000 deadbeef
2 00000000 0 5a5a1234 00000000
1 bfd00004 f 00000000 5a5a1234
1 bfd00008 f 00000000 00000000
1 c0000000 f 00000000 00000000
0 00000000 f 77777777 00000000
1 80000000 f 00000000 ff34ff78

// ==== all.f ====
source/soc_bus_pkg.sv
source/dbus_decoder.sv
source/data_ram.sv
source/gpio_regs.sv
source/ticker.sv
source/soc_dbus_top.sv
verification/soc_dbus_sva.sv
verification/tb_soc_dbus.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_soc_dbus -f all.f -o tb_soc_dbus &&
./obj_dir/tb_soc_dbus || { echo "Simulation did not pass."; exit 1; }
